//--- Bender.yml
package:
  name: circ_interp

sources:
  - design/op_pkg.sv
  - design/pos_pkg.sv
  - design/circ_arc_geometry.sv
  - design/circ_step_select.sv
  - design/circ_op_handler.sv
  - design/circ_interp_top.sv
  - target: test
    files:
      - dv/circ_interp_assert.sv
      - dv/circ_interp_tb.sv

//--- design/circ_arc_geometry.sv
`timescale 1ns/1ps

module circ_arc_geometry (
	input  op_pkg::op_cmd_t  op_cmd,
	input  op_pkg::op_arg_t  op_arg_x,
	input  op_pkg::op_arg_t  op_arg_y,
	input  op_pkg::op_arg_t  op_arg_i,
	input  op_pkg::op_arg_t  op_arg_j,
	input  logic             is_absolute,
	input  pos_pkg::pos_t    last_x,
	input  pos_pkg::pos_t    last_y,
	input  pos_pkg::pos_t    cur_x,
	input  pos_pkg::pos_t    cur_y,
	input  pos_pkg::pos_dir_t dir,
	input  logic             is_last_mvt,
	output pos_pkg::num_t    rel_x,
	output pos_pkg::num_t    rel_y,
	output pos_pkg::num_t    start_rel_x,
	output pos_pkg::num_t    start_rel_y,
	output pos_pkg::num_t    end_rel_x,
	output pos_pkg::num_t    end_rel_y,
	output pos_pkg::num_t    r_squared,
	output pos_pkg::num_t    r2_up,
	output pos_pkg::num_t    r2_down,
	output pos_pkg::num_t    r2_left,
	output pos_pkg::num_t    r2_right,
	output logic             is_cw,
	output pos_pkg::pulse_t  pulse_num_x,
	output pos_pkg::pulse_t  pulse_num_y,
	output pos_pkg::pos_t    new_x,
	output pos_pkg::pos_t    new_y
);

	pos_pkg::num_t start_x_n, start_y_n; // absolute start point, widened.
	pos_pkg::num_t cur_x_n, cur_y_n;     // absolute live position, widened.
	pos_pkg::num_t end_x_n, end_y_n;     // absolute end point.
	pos_pkg::num_t center_x, center_y;   // absolute circle center.

	function automatic pos_pkg::num_t square_num(input pos_pkg::num_t v);
		return v * v; // the calculation width covers every square used here.
	endfunction

	assign start_x_n = pos_pkg::num_t'(last_x); // signed cast sign-extends.
	assign start_y_n = pos_pkg::num_t'(last_y);
	assign cur_x_n   = pos_pkg::num_t'(cur_x);
	assign cur_y_n   = pos_pkg::num_t'(cur_y);

	// the end point is absolute or an offset from the start.
	assign end_x_n = is_absolute ? pos_pkg::num_t'(op_arg_x) : start_x_n + pos_pkg::num_t'(op_arg_x);
	assign end_y_n = is_absolute ? pos_pkg::num_t'(op_arg_y) : start_y_n + pos_pkg::num_t'(op_arg_y);

	assign center_x = start_x_n + pos_pkg::num_t'(op_arg_i); // I/J always relative to start.
	assign center_y = start_y_n + pos_pkg::num_t'(op_arg_j);

	assign rel_x       = cur_x_n - center_x;   // live position seen from the center.
	assign rel_y       = cur_y_n - center_y;
	assign start_rel_x = start_x_n - center_x; // equals -I.
	assign start_rel_y = start_y_n - center_y; // equals -J.
	assign end_rel_x   = end_x_n - center_x;
	assign end_rel_y   = end_y_n - center_y;

	assign r_squared = square_num(start_rel_x) + square_num(start_rel_y); // commanded radius.

	// squared radius after each of the four possible unit moves.
	assign r2_up    = square_num(rel_x) + square_num(rel_y + pos_pkg::num_t'(1));
	assign r2_down  = square_num(rel_x) + square_num(rel_y - pos_pkg::num_t'(1));
	assign r2_left  = square_num(rel_x - pos_pkg::num_t'(1)) + square_num(rel_y);
	assign r2_right = square_num(rel_x + pos_pkg::num_t'(1)) + square_num(rel_y);

	assign is_cw = (op_cmd == op_pkg::OP_CMD_G02); // G02 turns clockwise.

	always_comb begin
		pulse_num_x = '0; // idle axis sends no pulses.
		pulse_num_y = '0;
		new_x       = cur_x;
		new_y       = cur_y;
		if (is_last_mvt) begin
			pulse_num_x = pos_pkg::pulse_t'(end_x_n - cur_x_n); // remaining distance, truncated.
			pulse_num_y = pos_pkg::pulse_t'(end_y_n - cur_y_n);
			new_x       = pos_pkg::pos_t'(end_x_n); // land exactly on the end point.
			new_y       = pos_pkg::pos_t'(end_y_n);
		end else begin
			case (dir)
				pos_pkg::POS_DIR_UP: begin
					pulse_num_y = pos_pkg::pulse_t'(1);
					new_y       = cur_y + pos_pkg::pos_t'(1);
				end
				pos_pkg::POS_DIR_DOWN: begin
					pulse_num_y = pos_pkg::pulse_t'(-1);
					new_y       = cur_y - pos_pkg::pos_t'(1);
				end
				pos_pkg::POS_DIR_LEFT: begin
					pulse_num_x = pos_pkg::pulse_t'(-1);
					new_x       = cur_x - pos_pkg::pos_t'(1);
				end
				default: begin // right.
					pulse_num_x = pos_pkg::pulse_t'(1);
					new_x       = cur_x + pos_pkg::pos_t'(1);
				end
			endcase
		end
	end

endmodule : circ_arc_geometry

//--- design/circ_interp_top.sv
`timescale 1ns/1ps

module circ_interp_top (
	input  logic              clk,
	input  logic              arst_n,
	input  logic              op_valid,
	input  op_pkg::op_cmd_t   op_cmd,
	input  op_pkg::op_arg_t   op_arg_x,
	input  op_pkg::op_arg_t   op_arg_y,
	input  op_pkg::op_arg_t   op_arg_i,
	input  op_pkg::op_arg_t   op_arg_j,
	input  op_pkg::op_flags_t op_flags,
	input  logic              is_absolute,
	output logic              busy,
	output logic              step_valid,
	output pos_pkg::pulse_t   pulse_num_x,
	output pos_pkg::pulse_t   pulse_num_y,
	output pos_pkg::pos_t     pos_x,
	output pos_pkg::pos_t     pos_y,
	output logic              done
);

	op_pkg::op_cmd_t    l_cmd;                    // latched command code.
	op_pkg::op_arg_t    l_arg_x, l_arg_y;         // latched end point.
	op_pkg::op_arg_t    l_arg_i, l_arg_j;         // latched center offset.
	logic               l_absolute, full_circle;
	pos_pkg::pos_t      last_x, last_y;           // start of the running arc.
	pos_pkg::pos_t      new_x, new_y;             // position after this step.
	pos_pkg::step_cnt_t step_count;
	pos_pkg::num_t      rel_x, rel_y, start_rel_x, start_rel_y, end_rel_x, end_rel_y;
	pos_pkg::num_t      r_squared, r2_up, r2_down, r2_left, r2_right;
	logic               is_cw, is_last_mvt;
	pos_pkg::pos_dir_t  dir;

	circ_op_handler u_handler (
		.clk(clk), .arst_n(arst_n), .op_valid(op_valid), .op_cmd(op_cmd),
		.op_arg_x(op_arg_x), .op_arg_y(op_arg_y), .op_arg_i(op_arg_i), .op_arg_j(op_arg_j),
		.op_flags(op_flags), .is_absolute(is_absolute), .new_x(new_x), .new_y(new_y),
		.is_last_mvt(is_last_mvt), .l_cmd(l_cmd), .l_arg_x(l_arg_x), .l_arg_y(l_arg_y),
		.l_arg_i(l_arg_i), .l_arg_j(l_arg_j), .l_absolute(l_absolute),
		.full_circle(full_circle), .last_x(last_x), .last_y(last_y), .cur_x(pos_x),
		.cur_y(pos_y), .step_count(step_count), .busy(busy), .step_valid(step_valid),
		.done(done)
	);

	circ_arc_geometry u_geometry (
		.op_cmd(l_cmd), .op_arg_x(l_arg_x), .op_arg_y(l_arg_y), .op_arg_i(l_arg_i),
		.op_arg_j(l_arg_j), .is_absolute(l_absolute), .last_x(last_x), .last_y(last_y),
		.cur_x(pos_x), .cur_y(pos_y), .dir(dir), .is_last_mvt(is_last_mvt),
		.rel_x(rel_x), .rel_y(rel_y), .start_rel_x(start_rel_x), .start_rel_y(start_rel_y),
		.end_rel_x(end_rel_x), .end_rel_y(end_rel_y), .r_squared(r_squared), .r2_up(r2_up),
		.r2_down(r2_down), .r2_left(r2_left), .r2_right(r2_right), .is_cw(is_cw),
		.pulse_num_x(pulse_num_x), .pulse_num_y(pulse_num_y), .new_x(new_x), .new_y(new_y)
	);

	circ_step_select u_select (
		.is_cw(is_cw), .rel_x(rel_x), .rel_y(rel_y), .end_rel_x(end_rel_x),
		.end_rel_y(end_rel_y), .start_rel_x(start_rel_x), .start_rel_y(start_rel_y),
		.r_squared(r_squared), .r2_up(r2_up), .r2_down(r2_down), .r2_left(r2_left),
		.r2_right(r2_right), .full_circle(full_circle), .step_count(step_count),
		.dir(dir), .is_last_mvt(is_last_mvt)
	);

endmodule : circ_interp_top

//--- design/circ_op_handler.sv
`timescale 1ns/1ps

module circ_op_handler (
	input  logic               clk,
	input  logic               arst_n,
	input  logic               op_valid,
	input  op_pkg::op_cmd_t    op_cmd,
	input  op_pkg::op_arg_t    op_arg_x,
	input  op_pkg::op_arg_t    op_arg_y,
	input  op_pkg::op_arg_t    op_arg_i,
	input  op_pkg::op_arg_t    op_arg_j,
	input  op_pkg::op_flags_t  op_flags,
	input  logic               is_absolute,
	input  pos_pkg::pos_t      new_x,
	input  pos_pkg::pos_t      new_y,
	input  logic               is_last_mvt,
	output op_pkg::op_cmd_t    l_cmd,
	output op_pkg::op_arg_t    l_arg_x,
	output op_pkg::op_arg_t    l_arg_y,
	output op_pkg::op_arg_t    l_arg_i,
	output op_pkg::op_arg_t    l_arg_j,
	output logic               l_absolute,
	output logic               full_circle,
	output pos_pkg::pos_t      last_x,
	output pos_pkg::pos_t      last_y,
	output pos_pkg::pos_t      cur_x,
	output pos_pkg::pos_t      cur_y,
	output pos_pkg::step_cnt_t step_count,
	output logic               busy,
	output logic               step_valid,
	output logic               done
);

	typedef enum logic [1:0] {
		IDLE,   // waiting for a command.
		STEP,   // one motor step per cycle.
		FINISH  // arc complete, done is high.
	} state_t;

	state_t state, state_nxt;
	logic   accept; // command taken this cycle.

	assign accept = op_valid && (state != STEP); // strobes during an arc are dropped.

	always_comb begin
		state_nxt = state;
		case (state)
			IDLE, FINISH: begin
				state_nxt = accept ? STEP : IDLE; // finish lasts a single cycle.
			end
			STEP: begin
				if (is_last_mvt) begin
					state_nxt = FINISH; // this edge commits the final step.
				end
			end
			default: begin
				state_nxt = IDLE;
			end
		endcase
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state      <= IDLE;
			cur_x      <= '0; // the machine starts at the origin.
			cur_y      <= '0;
			step_count <= '0;
		end else begin
			state <= state_nxt;
			if (accept) begin
				step_count <= '0; // every arc counts from zero.
			end else if (state == STEP) begin
				cur_x <= new_x; // commit the step chosen this cycle.
				cur_y <= new_y;
				if (step_count != pos_pkg::STEP_CNT_MAX) begin
					step_count <= step_count + pos_pkg::step_cnt_t'(1);
				end
			end
		end
	end

	// command fields and start point held for the whole arc.
	always_ff @(posedge clk) begin
		if (accept) begin
			l_cmd       <= op_cmd;
			l_arg_x     <= op_arg_x;
			l_arg_y     <= op_arg_y;
			l_arg_i     <= op_arg_i;
			l_arg_j     <= op_arg_j;
			l_absolute  <= is_absolute;
			full_circle <= op_flags[op_pkg::OP_FLAGS_FULL_CIRCLE_BIT];
			last_x      <= cur_x; // the arc starts where the last one ended.
			last_y      <= cur_y;
		end
	end

	assign busy       = (state == STEP);
	assign step_valid = (state == STEP); // one step on every busy cycle.
	assign done       = (state == FINISH);

endmodule : circ_op_handler

//--- design/circ_step_select.sv
`timescale 1ns/1ps

module circ_step_select (
	input  logic               is_cw,
	input  pos_pkg::num_t      rel_x,
	input  pos_pkg::num_t      rel_y,
	input  pos_pkg::num_t      end_rel_x,
	input  pos_pkg::num_t      end_rel_y,
	input  pos_pkg::num_t      start_rel_x,
	input  pos_pkg::num_t      start_rel_y,
	input  pos_pkg::num_t      r_squared,
	input  pos_pkg::num_t      r2_up,
	input  pos_pkg::num_t      r2_down,
	input  pos_pkg::num_t      r2_left,
	input  pos_pkg::num_t      r2_right,
	input  logic               full_circle,
	input  pos_pkg::step_cnt_t step_count,
	output pos_pkg::pos_dir_t  dir,
	output logic               is_last_mvt
);

	pos_pkg::pos_dir_t h_dir, v_dir; // tangent-aligned horizontal and vertical candidates.
	pos_pkg::num_t     h_err, v_err; // radius error of each candidate.
	pos_pkg::num_t     tgt_x, tgt_y; // point the arc closes on.
	pos_pkg::num_t     manhattan;    // distance left to the target.
	logic              min_done;     // enough steps for a full circle.

	function automatic pos_pkg::num_t abs_num(input pos_pkg::num_t v);
		return (v < 0) ? -v : v;
	endfunction

	// the tangent is (-y, x) counter-clockwise and (y, -x) clockwise.
	always_comb begin
		if (is_cw) begin
			h_dir = (rel_y >= 0) ? pos_pkg::POS_DIR_RIGHT : pos_pkg::POS_DIR_LEFT;
			v_dir = (rel_x >= 0) ? pos_pkg::POS_DIR_DOWN : pos_pkg::POS_DIR_UP;
		end else begin
			h_dir = (rel_y >= 0) ? pos_pkg::POS_DIR_LEFT : pos_pkg::POS_DIR_RIGHT;
			v_dir = (rel_x >= 0) ? pos_pkg::POS_DIR_UP : pos_pkg::POS_DIR_DOWN;
		end
	end

	assign h_err = abs_num(((h_dir == pos_pkg::POS_DIR_LEFT) ? r2_left : r2_right) - r_squared);
	assign v_err = abs_num(((v_dir == pos_pkg::POS_DIR_UP) ? r2_up : r2_down) - r_squared);

	always_comb begin
		if (v_err < h_err) begin
			dir = v_dir; // vertical move stays closer to the circle.
		end else begin
			dir = h_dir; // ties go to the horizontal axis.
		end
	end

	// a full circle closes back on its start point.
	assign tgt_x = full_circle ? start_rel_x : end_rel_x;
	assign tgt_y = full_circle ? start_rel_y : end_rel_y;

	assign manhattan = abs_num(rel_x - tgt_x) + abs_num(rel_y - tgt_y);
	assign min_done  = (step_count >= pos_pkg::step_cnt_t'(pos_pkg::MIN_FULL_STEPS));

	// near the target finish, the saturated counter ends a runaway arc.
	assign is_last_mvt = ((manhattan <= pos_pkg::num_t'(2)) && (!full_circle || min_done))
		|| (step_count == pos_pkg::STEP_CNT_MAX);

endmodule : circ_step_select

//--- design/op_pkg.sv
package op_pkg;

	// arc command codes, one bit is enough for the two arc senses.
	typedef enum logic {
		OP_CMD_G02 = 1'b0, // clockwise arc.
		OP_CMD_G03 = 1'b1  // counter-clockwise arc.
	} op_cmd_t;

	localparam int OP_ARG_BITS = 8; // width of each of X, Y, I and J.

	// signed argument, I/J are always offsets from the start point.
	typedef logic signed [OP_ARG_BITS-1:0] op_arg_t;

	localparam int OP_FLAGS_BITS = 2; // number of flag bits carried with a command.

	typedef logic [OP_FLAGS_BITS-1:0] op_flags_t;

	localparam int OP_FLAGS_FULL_CIRCLE_BIT = 0; // set to draw a complete circle.
	localparam int OP_FLAGS_AXES_CROSS_BIT  = 1; // reserved, the engine ignores it.

endpackage : op_pkg

//--- design/pos_pkg.sv
package pos_pkg;

	localparam int POS_BITS = 8; // position coordinate width.

	typedef logic signed [POS_BITS-1:0] pos_t;

	// wide enough to hold the sum of two squares of 9-bit values.
	localparam int NUM_BITS = 20;

	typedef logic signed [NUM_BITS-1:0] num_t;

	localparam int PULSE_BITS = 8; // pulse count width per axis and step.

	typedef logic signed [PULSE_BITS-1:0] pulse_t;

	localparam int STEP_BITS = 8; // width of the step counter.

	typedef logic [STEP_BITS-1:0] step_cnt_t;

	localparam step_cnt_t STEP_CNT_MAX = '1; // counter saturates here and forces the end.

	// unit move directions of one step.
	typedef enum logic [1:0] {
		POS_DIR_UP,    // +Y.
		POS_DIR_DOWN,  // -Y.
		POS_DIR_LEFT,  // -X.
		POS_DIR_RIGHT  // +X.
	} pos_dir_t;

	localparam int MIN_FULL_STEPS = 4; // a full circle may not close before this.

endpackage : pos_pkg

//--- dv/circ_interp_assert.sv
`timescale 1ns/1ps

module circ_interp_assert (
	input logic              clk,
	input logic              arst_n,
	input logic              op_valid,
	input logic              is_absolute,
	input op_pkg::op_arg_t   op_arg_x, op_arg_y, op_arg_i, op_arg_j,
	input op_pkg::op_flags_t op_flags,
	input op_pkg::op_arg_t   l_arg_x, l_arg_y, l_arg_i, l_arg_j,
	input logic              busy,
	input logic              step_valid,
	input logic              is_last_mvt,
	input logic              done,
	input pos_pkg::pulse_t   pulse_num_x, pulse_num_y,
	input pos_pkg::pos_t     pos_x, pos_y
);

	int unsigned   fail_count = 0; // failed checks so far.
	string         fail_name, fail_exp, fail_act, fail_what; // details of the first failure.
	int            start_x, start_y, cen_x, cen_y, end_x, end_y; // model of the running arc.
	int            r2_cmd, steps, rel_x, rel_y, rad_err, tol;
	logic          full_cmd, prev_step, prev_unit;
	pos_pkg::pos_t exp_x, exp_y; // position the last step must lead to.

	task automatic record_failure(input string name, input string exp_s, input string act_s,
		input string what);
		if (fail_count == 0) begin
			fail_name = name; // only the first failure is kept.
			fail_exp  = exp_s;
			fail_act  = act_s;
			fail_what = what;
		end
		fail_count++;
	endtask

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			prev_step <= 1'b0;
			prev_unit <= 1'b0;
			exp_x     <= '0;
			exp_y     <= '0;
		end else begin
			prev_step <= step_valid;
			prev_unit <= ((pulse_num_x == 1 || pulse_num_x == -1) && pulse_num_y == 0)
				|| (pulse_num_x == 0 && (pulse_num_y == 1 || pulse_num_y == -1));
			exp_x     <= pos_x + pulse_num_x; // wraps like the 8-bit position register.
			exp_y     <= pos_y + pulse_num_y;
		end
	end

	// the command is taken from the bus when the engine is free to accept it.
	always_ff @(posedge clk) begin
		if (op_valid && !busy) begin
			start_x  <= pos_x;
			start_y  <= pos_y;
			cen_x    <= pos_x + op_arg_i; // center offset is relative to the start.
			cen_y    <= pos_y + op_arg_j;
			end_x    <= is_absolute ? op_arg_x : pos_x + op_arg_x;
			end_y    <= is_absolute ? op_arg_y : pos_y + op_arg_y;
			r2_cmd   <= op_arg_i * op_arg_i + op_arg_j * op_arg_j;
			full_cmd <= op_flags[op_pkg::OP_FLAGS_FULL_CIRCLE_BIT];
			steps    <= 0;
		end else if (step_valid) begin
			steps <= steps + 1;
		end
	end

	assign rel_x   = pos_x - cen_x;
	assign rel_y   = pos_y - cen_y;
	assign rad_err = rel_x * rel_x + rel_y * rel_y - r2_cmd; // distance from the ideal circle.
	assign tol     = 2 * ((rel_x < 0 ? -rel_x : rel_x) + (rel_y < 0 ? -rel_y : rel_y)) + 2;

	reset_idle: assert property (@(posedge clk) (!arst_n || $rose(arst_n))
		|-> (!busy && !step_valid && !done && pos_x == 0 && pos_y == 0))
		else begin
			record_failure("reset_idle", "", "", "outputs are not idle at the origin around reset");
			$error("reset state wrong");
		end

	unit_step: assert property (@(posedge clk) disable iff (!arst_n)
		(prev_step && !done) |-> prev_unit)
		else begin
			record_failure("unit_step", "", "", "a non-final step did not move one unit on one axis");
			$error("non-unit step");
		end

	pos_track: assert property (@(posedge clk) disable iff (!arst_n)
		prev_step |-> (pos_x == exp_x && pos_y == exp_y))
		else begin
			record_failure("pos_track", $sformatf("%0d,%0d", $sampled(exp_x), $sampled(exp_y)),
				$sformatf("%0d,%0d", $sampled(pos_x), $sampled(pos_y)), "");
			$error("position does not follow the pulses");
		end

	radius_tol: assert property (@(posedge clk) disable iff (!arst_n)
		(prev_step && !done) |-> (rad_err <= tol && -rad_err <= tol))
		else begin
			record_failure("radius_tol", $sformatf("|err| <= %0d", $sampled(tol)),
				$sformatf("%0d", $sampled(rad_err)), "");
			$error("step left the circle");
		end

	end_point: assert property (@(posedge clk) disable iff (!arst_n)
		done |-> (pos_x == pos_pkg::pos_t'(end_x) && pos_y == pos_pkg::pos_t'(end_y)))
		else begin
			record_failure("end_point", $sformatf("%0d,%0d", $sampled(end_x), $sampled(end_y)),
				$sformatf("%0d,%0d", $sampled(pos_x), $sampled(pos_y)), "");
			$error("arc ended off its end point");
		end

	// a full circle must bring the engine back to where the arc began.
	full_close: assert property (@(posedge clk) disable iff (!arst_n) (done && full_cmd)
		|-> (pos_x == pos_pkg::pos_t'(start_x) && pos_y == pos_pkg::pos_t'(start_y)
			&& steps >= pos_pkg::MIN_FULL_STEPS))
		else begin
			record_failure("full_close", "", "", "full circle did not close after enough steps");
			$error("full circle too short");
		end

	done_shape: assert property (@(posedge clk) disable iff (!arst_n)
		done |-> (prev_step && !step_valid) ##1 !done)
		else begin
			record_failure("done_shape", "", "", "done is not a single pulse after the last step");
			$error("done pulse wrong");
		end

	last_done: assert property (@(posedge clk) disable iff (!arst_n)
		(step_valid && is_last_mvt) |=> done)
		else begin
			record_failure("last_done", "", "", "the final step was not followed by done");
			$error("done missing");
		end

	accept_busy: assert property (@(posedge clk) disable iff (!arst_n)
		(op_valid && !busy) |=> busy)
		else begin
			record_failure("accept_busy", "", "", "an accepted command did not raise busy");
			$error("busy missing");
		end

	ignore_busy: assert property (@(posedge clk) disable iff (!arst_n) (op_valid && busy)
		|=> ($stable(l_arg_x) && $stable(l_arg_y) && $stable(l_arg_i) && $stable(l_arg_j)))
		else begin
			record_failure("ignore_busy", "", "", "a command strobe while busy was taken");
			$error("busy strobe accepted");
		end

endmodule : circ_interp_assert

bind circ_interp_top circ_interp_assert u_assert (.*);

//--- dv/circ_interp_tb.sv
`timescale 1ns/1ps

module circ_interp_tb;

	localparam int TIMEOUT_CYCLES = 30 * 300; // commands times the longest arc.

	logic              clk = 1'b0;
	logic              arst_n, op_valid, is_absolute, busy, step_valid, done;
	op_pkg::op_cmd_t   op_cmd;
	op_pkg::op_arg_t   op_arg_x, op_arg_y, op_arg_i, op_arg_j;
	op_pkg::op_flags_t op_flags;
	pos_pkg::pulse_t   pulse_num_x, pulse_num_y;
	pos_pkg::pos_t     pos_x, pos_y;
	int                cycle_count = 0;
	int                model_x = 0; // where the engine stands after the last command.
	int                model_y = 0;

	circ_interp_top UUT (.*);

	always #4 clk = ~clk; // 8 ns period.

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("FAILED timeout: the run did not end within %0d cycles", TIMEOUT_CYCLES);
			$display("STATUS: FAIL");
			$fatal(1, "run stopped by the cycle limit");
		end
	end

	// assertion actions run at the rising edge, so the falling edge sees them settled.
	always @(negedge clk) begin
		if (UUT.u_assert.fail_count != 0) begin
			if (UUT.u_assert.fail_what == "") begin
				$display("FAILED %s: expected %s, actual %s", UUT.u_assert.fail_name,
					UUT.u_assert.fail_exp, UUT.u_assert.fail_act);
			end else begin
				$display("FAILED %s: %s", UUT.u_assert.fail_name, UUT.u_assert.fail_what);
			end
			$display("STATUS: FAIL");
			$fatal(1, "assertion failed");
		end
	end

	function automatic int int_sqrt(input int v);
		int s;
		s = 0;
		while ((s + 1) * (s + 1) <= v) begin
			s++;
		end
		return s;
	endfunction

	task automatic send_command(input op_pkg::op_cmd_t cmd, input int x, input int y,
		input int i, input int j, input logic absolute, input logic full);
		@(posedge clk);
		op_valid    <= 1'b1;
		op_cmd      <= cmd;
		op_arg_x    <= op_pkg::op_arg_t'(x);
		op_arg_y    <= op_pkg::op_arg_t'(y);
		op_arg_i    <= op_pkg::op_arg_t'(i);
		op_arg_j    <= op_pkg::op_arg_t'(j);
		is_absolute <= absolute;
		op_flags    <= full ? op_pkg::op_flags_t'(1 << op_pkg::OP_FLAGS_FULL_CIRCLE_BIT) : '0;
		@(posedge clk);
		op_valid <= 1'b0; // one-cycle strobe.
	endtask

	task automatic run_arc(input op_pkg::op_cmd_t cmd, input int x, input int y, input int i,
		input int j, input logic absolute, input logic full, input logic strobe_busy);
		send_command(cmd, x, y, i, j, absolute, full);
		if (strobe_busy) begin
			do @(negedge clk); while (!busy);
			send_command(op_pkg::OP_CMD_G02, 40, -40, 7, 7, 1'b1, 1'b0); // must be dropped.
		end
		do @(negedge clk); while (!done);
		model_x = absolute ? x : model_x + x;
		model_y = absolute ? y : model_y + y;
	endtask

	task automatic random_arc();
		int              i, j, r2, cx, cy, ex, ey;
		logic            absolute;
		op_pkg::op_cmd_t cmd;
		do begin
			i  = int'($urandom_range(28)) - 14;
			j  = int'($urandom_range(28)) - 14;
			r2 = i * i + j * j;
			cx = model_x + i; // keep the center near the origin so positions stay small.
			cy = model_y + j;
		end while (r2 < 9 || r2 > 400 || cx < -30 || cx > 30 || cy < -30 || cy > 30);
		ex = int'($urandom_range(2 * int_sqrt(r2))) - int_sqrt(r2);
		ey = int_sqrt(r2 - ex * ex); // end point on the circle, rounded down.
		if ($urandom_range(1) == 1) begin
			ey = -ey;
		end
		absolute = ($urandom_range(1) == 1);
		cmd      = ($urandom_range(1) == 1) ? op_pkg::OP_CMD_G03 : op_pkg::OP_CMD_G02;
		run_arc(cmd, absolute ? cx + ex : cx + ex - model_x, absolute ? cy + ey : cy + ey - model_y,
			i, j, absolute, 1'b0, 1'b0);
	endtask

	initial begin
		arst_n      = 1'b1;
		op_valid    = 1'b0;
		op_cmd      = op_pkg::OP_CMD_G02;
		op_arg_x    = '0;
		op_arg_y    = '0;
		op_arg_i    = '0;
		op_arg_j    = '0;
		op_flags    = '0;
		is_absolute = 1'b0;
		void'($urandom(32'hf659));
		#1 arst_n = 1'b0; // a clean falling edge resets every flop at once.
		repeat (5) @(posedge clk);
		arst_n <= 1'b1;
		run_arc(op_pkg::OP_CMD_G03, -10, 10, -10, 0, 1'b0, 1'b0, 1'b0); // quarter to (-10,10).
		run_arc(op_pkg::OP_CMD_G02, 0, 0, 0, -10, 1'b1, 1'b0, 1'b1); // back to the origin.
		run_arc(op_pkg::OP_CMD_G03, 0, 0, 5, 0, 1'b0, 1'b1, 1'b0); // full circle, radius 5.
		run_arc(op_pkg::OP_CMD_G02, -6, 6, 0, 6, 1'b0, 1'b0, 1'b0); // quarter from the bottom.
		repeat (20) random_arc();
		repeat (2) @(posedge clk);
		@(negedge clk);
		if (UUT.u_assert.fail_count == 0) begin
			$display("STATUS: PASS");
			$finish;
		end else begin
			$display("FAILED run: %0d assertion failures", UUT.u_assert.fail_count);
			$display("STATUS: FAIL");
			$fatal(1, "assertion failures at the end of the run");
		end
	end

endmodule : circ_interp_tb

//--- filelist.f
design/op_pkg.sv
design/pos_pkg.sv
design/circ_arc_geometry.sv
design/circ_step_select.sv
design/circ_op_handler.sv
design/circ_interp_top.sv
dv/circ_interp_assert.sv
dv/circ_interp_tb.sv
